// ==== build.f ====
soc_pkg.sv
mem_port.sv
machine_timer.sv
plic.sv
bus_decoder.sv
soc_top.sv
tb_clock.sv
soc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@! grep -q "Result: FAILED" $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== soc_tb.sv ====
`timescale 1ns/1ns

module soc_tb import soc_pkg::*; ();
    localparam int RAM_WORDS = 1024;
    localparam int NUM_SRC   = 8;
    localparam int BUS_LIMIT = 10; // cycles before a transfer counts as hung

    localparam logic [ADDR_W-1:0] PENDING = PLIC_BASE + PLIC_PENDING_OFS;
    localparam logic [ADDR_W-1:0] ENABLE0 = PLIC_BASE + PLIC_ENABLE_OFS;
    localparam logic [ADDR_W-1:0] ENABLE1 = ENABLE0 + PLIC_CTX_ENABLE_STRIDE;
    localparam logic [ADDR_W-1:0] THRESH0 = PLIC_BASE + PLIC_THRESHOLD_OFS;
    localparam logic [ADDR_W-1:0] THRESH1 = THRESH0 + PLIC_CTX_STRIDE;
    localparam logic [ADDR_W-1:0] CLAIM0  = PLIC_BASE + PLIC_CLAIM_OFS;
    localparam logic [ADDR_W-1:0] CLAIM1  = CLAIM0 + PLIC_CTX_STRIDE;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PULSE, OP_IRQ} op_t;

    // one table row; for OP_IRQ want holds {meip, seip, mtip}
    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        ls_type_t          ls;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] want;
        logic [3:0]        cyc;
    } step_t;

    logic               CLOCK_50;
    logic               KEY0;
    bus_req_t           bus_req;
    bus_rsp_t           bus_rsp;
    logic [NUM_SRC-1:0] irq_src;
    logic               meip;
    logic               seip;
    logic               mtip;

    step_t       steps [$];
    int          mismatches = 0;
    int          failures = 0;
    int          limit_cycles = 0;
    integer      seed;
    logic [63:0] rnd;
    logic [63:0] rd_val;
    logic [63:0] t0;
    logic [63:0] t1;
    int          cycles;
    int          waited;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(4)) clock_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    soc_top #(.RAM_WORDS(RAM_WORDS), .NUM_SRC(NUM_SRC)) soc_top_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip),
        .mtip     (mtip)
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH %s: got %h expected %h", name, got, want);
        end
    endtask

    function automatic void write_step(logic [ADDR_W-1:0] addr, ls_type_t ls,
                                       logic [DATA_W-1:0] data, logic [3:0] cyc);
        steps.push_back('{OP_WR, addr, ls, data, 64'd0, cyc});
    endfunction

    function automatic void read_step(logic [ADDR_W-1:0] addr, ls_type_t ls,
                                      logic [DATA_W-1:0] want, logic [3:0] cyc);
        steps.push_back('{OP_RD, addr, ls, 64'd0, want, cyc});
    endfunction

    function automatic void pulse_step(int src);
        steps.push_back('{OP_PULSE, 32'd0, LS_W, 64'(src), 64'd0, 4'd0});
    endfunction

    function automatic void irq_step(logic [2:0] want);
        steps.push_back('{OP_IRQ, 32'd0, LS_W, 64'd0, 64'(want), 4'd0});
    endfunction

    // one enable pulse, then wait for the matching done
    task automatic bus_access(input logic is_rd, input logic [ADDR_W-1:0] addr,
                              input ls_type_t ls, input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output int n);
        logic done;
        n = 0;
        @(posedge CLOCK_50);
        bus_req.addr    <= addr;
        bus_req.ls_type <= ls;
        bus_req.wdata   <= wdata;
        bus_req.rd_en   <= is_rd;
        bus_req.wr_en   <= !is_rd;
        do begin
            @(posedge CLOCK_50);
            n++;
            bus_req.rd_en <= 1'b0;
            bus_req.wr_en <= 1'b0;
            @(negedge CLOCK_50); // done settled here
            done = is_rd ? bus_rsp.read_done : bus_rsp.write_done;
        end while (!done && n < BUS_LIMIT);
        if (!done) begin
            failures++;
            $display("transfer to address %h never completed", addr);
        end
        rdata = bus_rsp.rdata;
    endtask

    task automatic pulse_source(input int src);
        @(posedge CLOCK_50);
        irq_src[src] <= 1'b1;
        @(posedge CLOCK_50);
        irq_src[src] <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    task automatic run_step(input int i, input step_t s);
        logic [DATA_W-1:0] got;
        int                n;
        case (s.op)
            OP_WR, OP_RD: begin
                bus_access(s.op == OP_RD, s.addr, s.ls, s.wdata, got, n);
                if (s.op == OP_RD) check($sformatf("step %0d bus_rsp.rdata", i), got, s.want);
                check($sformatf("step %0d cycles", i), 64'(n), 64'(s.cyc));
            end
            OP_PULSE: pulse_source(int'(s.wdata));
            default: begin
                @(negedge CLOCK_50);
                check($sformatf("step %0d {meip,seip,mtip}", i), {61'd0, meip, seip, mtip},
                      s.want);
            end
        endcase
    endtask

    initial begin
        seed = 20489;
        bus_req <= '0;
        irq_src <= '0;
        rnd[63:32] = $random(seed);
        rnd[31:0]  = $random(seed);

        read_step(32'h4000_0000, LS_W, 64'd0, 2); // unmapped
        irq_step(3'b000);
        write_step(RAM_BASE + 1, LS_B, 64'hA5, 2);
        write_step(RAM_BASE + 6, LS_H, 64'h8234, 2);  // upper half of word 1
        write_step(RAM_BASE + 8, LS_W, 64'h1122_3344, 2);
        write_step(RAM_BASE + 9, LS_B, 64'h99, 2);    // lane 1 over a full word
        write_step(RAM_BASE + 12, LS_W, 64'hCAFE_F00D, 2);
        read_step(RAM_BASE + 1, LS_B, 64'hFFFF_FFFF_FFFF_FFA5, 2);
        read_step(RAM_BASE + 1, LS_BU, 64'hA5, 2);
        read_step(RAM_BASE + 6, LS_H, 64'hFFFF_FFFF_FFFF_8234, 2);
        read_step(RAM_BASE + 6, LS_HU, 64'h8234, 2);
        read_step(RAM_BASE + 8, LS_W, 64'h0000_0000_1122_9944, 2);
        read_step(RAM_BASE + 8, LS_WU, 64'h1122_9944, 2);
        read_step(RAM_BASE + 12, LS_W, 64'hFFFF_FFFF_CAFE_F00D, 2);
        read_step(RAM_BASE + 12, LS_WU, 64'hCAFE_F00D, 2);
        write_step(RAM_BASE + 32, LS_D, rnd, 3);
        read_step(RAM_BASE + 32, LS_D, rnd, 3);
        read_step(RAM_BASE + 36, LS_W, {{32{rnd[63]}}, rnd[63:32]}, 2);
        read_step(MTIMECMP_ADDR, LS_D, 64'(MTIMECMP_RESET), 2);
        write_step(MTIMECMP_ADDR, LS_D, 64'h0123_4567_89AB_CDEF, 2);
        read_step(MTIMECMP_ADDR, LS_D, 64'h0123_4567_89AB_CDEF, 2);
        write_step(PLIC_BASE + 12, LS_W, 64'd2, 2);   // source 3 priority
        read_step(PLIC_BASE + 12, LS_W, 64'd2, 2);
        write_step(ENABLE0, LS_W, 64'h08, 2);
        read_step(ENABLE0, LS_W, 64'h08, 2);
        write_step(THRESH0, LS_W, 64'd1, 2);
        read_step(THRESH0, LS_W, 64'd1, 2);
        pulse_step(3);
        irq_step(3'b100);
        read_step(PENDING, LS_W, 64'h08, 2);
        read_step(CLAIM0, LS_W, 64'd3, 2);
        irq_step(3'b000);
        read_step(PENDING, LS_W, 64'h00, 2);
        write_step(PLIC_BASE + 20, LS_W, 64'd3, 2);   // source 5 priority
        write_step(ENABLE1, LS_W, 64'h20, 2);
        write_step(THRESH1, LS_W, 64'd1, 2);
        pulse_step(5);
        irq_step(3'b010);
        write_step(THRESH1, LS_W, 64'd3, 2);          // priority no longer above
        irq_step(3'b000);
        write_step(THRESH1, LS_W, 64'd2, 2);
        read_step(CLAIM1, LS_W, 64'd5, 2);
        irq_step(3'b000);
        limit_cycles = steps.size() * 20 + 300;

        wait (KEY0 === 1'b1);
        @(negedge CLOCK_50);
        check("bus_rsp.read_done", 64'(bus_rsp.read_done), 64'd1);
        check("bus_rsp.write_done", 64'(bus_rsp.write_done), 64'd1);
        foreach (steps[i]) run_step(i, steps[i]);

        // mtime runs and the compare raises mtip
        bus_access(1'b1, MTIME_ADDR, LS_D, '0, t0, cycles);
        bus_access(1'b1, MTIME_ADDR, LS_D, '0, t1, cycles);
        check("mtime increasing", 64'(t1 > t0), 64'd1);
        bus_access(1'b0, MTIMECMP_ADDR, LS_D, t1 + 64'd20, rd_val, cycles);
        waited = 0;
        while (!mtip && waited < 40) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!mtip) begin
            failures++;
            $display("mtip did not rise within 40 cycles of the compare value");
        end
        bus_access(1'b0, MTIMECMP_ADDR, LS_D, '1, rd_val, cycles);
        check("mtip", 64'(mtip), 64'd0);

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge CLOCK_50);
        failures++;
        $display("watchdog expired after %0d cycles, run stopped", limit_cycles);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic CLOCK_50,
    output logic KEY0
);
    initial begin
        CLOCK_50 = 1'b0;
        forever #(PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    // released on a falling edge, clear of the sampling edge
    initial begin
        KEY0 = 1'b0;
        #(PERIOD * RESET_CYCLES) KEY0 = 1'b1;
    end

endmodule

// ==== soc_top.sv ====
`timescale 1ns/1ns

module soc_top import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024,
    parameter int NUM_SRC   = 8
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  bus_req_t           bus_req,
    output bus_rsp_t           bus_rsp,
    input  logic [NUM_SRC-1:0] irq_src,
    output logic               meip,
    output logic               seip,
    output logic               mtip
);
    tgt_req_t tgt_req;   // shared by all targets
    logic     ram_sel;
    logic     timer_sel;
    logic     plic_sel;
    tgt_rsp_t ram_rsp;
    tgt_rsp_t timer_rsp;
    tgt_rsp_t plic_rsp;

    bus_decoder #(.RAM_WORDS(RAM_WORDS)) decoder_inst (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .tgt_req   (tgt_req),
        .ram_sel   (ram_sel),
        .timer_sel (timer_sel),
        .plic_sel  (plic_sel),
        .ram_rsp   (ram_rsp),
        .timer_rsp (timer_rsp),
        .plic_rsp  (plic_rsp)
    );

    mem_port #(.RAM_WORDS(RAM_WORDS)) ram_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .sel      (ram_sel),
        .tgt_req  (tgt_req),
        .rsp      (ram_rsp)
    );

    machine_timer timer_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .sel      (timer_sel),
        .tgt_req  (tgt_req),
        .rsp      (timer_rsp),
        .mtip     (mtip)
    );

    plic #(.NUM_SRC(NUM_SRC)) plic_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .sel      (plic_sel),
        .tgt_req  (tgt_req),
        .rsp      (plic_rsp),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp,
    output tgt_req_t tgt_req,
    output logic     ram_sel,
    output logic     timer_sel,
    output logic     plic_sel,
    input  tgt_rsp_t ram_rsp,
    input  tgt_rsp_t timer_rsp,
    input  tgt_rsp_t plic_rsp
);
    localparam logic [ADDR_W-1:0] RAM_END = RAM_BASE + ADDR_W'(RAM_WORDS * 4);

    logic              req_seen;
    logic              ram_hit;
    logic              timer_hit;
    logic              plic_hit;
    logic [ADDR_W-1:0] offset;
    logic              miss_q;   // unmapped access, answered here
    logic              done_now;
    logic [DATA_W-1:0] tgt_rdata;
    logic              read_done;
    logic              write_done;
    logic [DATA_W-1:0] rdata_q;

    assign req_seen  = bus_req.rd_en || bus_req.wr_en;
    assign ram_hit   = (bus_req.addr >= RAM_BASE) && (bus_req.addr < RAM_END);
    assign timer_hit = (bus_req.addr == MTIME_ADDR) || (bus_req.addr == MTIMECMP_ADDR);
    assign plic_hit  = (bus_req.addr >= PLIC_BASE) && (bus_req.addr < PLIC_BASE + PLIC_SIZE);

    always_comb begin
        if (ram_hit)
            offset = bus_req.addr - RAM_BASE;
        else if (plic_hit)
            offset = bus_req.addr - PLIC_BASE;
        else
            offset = bus_req.addr; // timer keeps the full address
    end

    assign done_now  = (ram_sel && ram_rsp.ack) || (timer_sel && timer_rsp.ack)
                     || (plic_sel && plic_rsp.ack) || miss_q;
    assign tgt_rdata = ({DATA_W{ram_sel}} & ram_rsp.rdata)
                     | ({DATA_W{timer_sel}} & timer_rsp.rdata)
                     | ({DATA_W{plic_sel}} & plic_rsp.rdata); // zero on a miss

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done  <= 1'b1;
            write_done <= 1'b1;
            ram_sel    <= 1'b0;
            timer_sel  <= 1'b0;
            plic_sel   <= 1'b0;
            miss_q     <= 1'b0;
        end else if (req_seen) begin
            if (bus_req.rd_en) read_done <= 1'b0;
            if (bus_req.wr_en) write_done <= 1'b0;
            ram_sel   <= ram_hit;
            timer_sel <= timer_hit;
            plic_sel  <= plic_hit;
            miss_q    <= !(ram_hit || timer_hit || plic_hit);
        end else if (done_now) begin
            read_done  <= 1'b1;
            write_done <= 1'b1;
            ram_sel    <= 1'b0;
            timer_sel  <= 1'b0;
            plic_sel   <= 1'b0;
            miss_q     <= 1'b0;
        end
    end

    // request payload and load result
    always_ff @(posedge CLOCK_50) begin
        if (req_seen) begin
            tgt_req <= '{offset: offset, ls_type: bus_req.ls_type,
                         wdata: bus_req.wdata, is_write: bus_req.wr_en};
        end
        if (done_now && !tgt_req.is_write) rdata_q <= tgt_rdata;
    end

    assign bus_rsp = '{rdata: rdata_q, read_done: read_done, write_done: write_done};

    a_one_at_a_time: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req_seen |-> (read_done && write_done))
        else $error("bus request issued while a transfer is still open");

    // longest target is a two-beat RAM access
    a_read_bounded: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(read_done) |-> ##[1:2] read_done)
        else $error("read did not complete within two cycles of capture");

endmodule

// ==== plic.sv ====
`timescale 1ns/1ns

module plic import soc_pkg::*; #(
    parameter int NUM_SRC = 8
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               sel,
    input  tgt_req_t           tgt_req,
    output tgt_rsp_t           rsp,
    input  logic [NUM_SRC-1:0] irq_src,
    output logic               meip,
    output logic               seip
);
    localparam int ID_W = $clog2(NUM_SRC);

    logic [PRIO_W-1:0]  prio [NUM_SRC];
    logic [NUM_SRC-1:0] pending;
    logic [NUM_SRC-1:0] src_q;
    logic [NUM_SRC-1:0] enable [2];    // ctx 0 machine, ctx 1 supervisor
    logic [PRIO_W-1:0]  threshold [2];
    logic [ID_W-1:0]    claim_id [2];

    logic [ADDR_W-1:0]  ofs;
    logic [ADDR_W-3:0]  prio_idx;
    logic               prio_hit;
    logic               pend_hit;
    logic [1:0]         en_hit;
    logic [1:0]         thr_hit;
    logic [1:0]         claim_hit;
    logic [NUM_SRC-1:0] claim_clr;
    logic [DATA_W-1:0]  rd_data;

    assign ofs      = tgt_req.offset;
    assign prio_idx = ofs[ADDR_W-1:2]; // one priority per word
    assign prio_hit = (ofs < PLIC_PENDING_OFS) && (prio_idx < NUM_SRC);
    assign pend_hit = (ofs == PLIC_PENDING_OFS);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_hit[c]    = (ofs == PLIC_ENABLE_OFS + c * PLIC_CTX_ENABLE_STRIDE);
            thr_hit[c]   = (ofs == PLIC_THRESHOLD_OFS + c * PLIC_CTX_STRIDE);
            claim_hit[c] = (ofs == PLIC_CLAIM_OFS + c * PLIC_CTX_STRIDE);
        end
    end

    // lowest pending id wins, so scan downward
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = '0;
            for (int i = NUM_SRC - 1; i > 0; i--) begin
                if (pending[i] && enable[c][i] && prio[i] > threshold[c]) begin
                    claim_id[c] = ID_W'(i);
                end
            end
        end
    end

    // a claim read retires the id it returns
    always_comb begin
        claim_clr = '0;
        for (int c = 0; c < 2; c++) begin
            if (sel && !tgt_req.is_write && claim_hit[c]) claim_clr[claim_id[c]] = 1'b1;
        end
    end

    always_comb begin
        rd_data = '0;
        if (prio_hit) rd_data = DATA_W'(prio[prio_idx[ID_W-1:0]]);
        if (pend_hit) rd_data = DATA_W'(pending);
        for (int c = 0; c < 2; c++) begin
            if (en_hit[c])    rd_data = DATA_W'(enable[c]);
            if (thr_hit[c])   rd_data = DATA_W'(threshold[c]);
            if (claim_hit[c]) rd_data = DATA_W'(claim_id[c]);
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= '0;
            src_q   <= '0;
            for (int i = 0; i < NUM_SRC; i++) prio[i] <= '0;
            for (int c = 0; c < 2; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            src_q   <= irq_src;
            pending <= (pending & ~claim_clr) | (irq_src & ~src_q); // edge sets
            if (sel && tgt_req.is_write) begin
                if (prio_hit) prio[prio_idx[ID_W-1:0]] <= tgt_req.wdata[PRIO_W-1:0];
                for (int c = 0; c < 2; c++) begin
                    if (en_hit[c])  enable[c]    <= tgt_req.wdata[NUM_SRC-1:0];
                    if (thr_hit[c]) threshold[c] <= tgt_req.wdata[PRIO_W-1:0];
                end
            end
        end
    end

    assign rsp  = '{ack: sel, rdata: rd_data};
    assign meip = (claim_id[0] != '0);
    assign seip = (claim_id[1] != '0);

    // id 0 is reserved
    a_src0_idle: assert property (@(posedge CLOCK_50) disable iff (!KEY0) !pending[0])
        else $error("reserved source 0 became pending");

endmodule

// ==== machine_timer.sv ====
`timescale 1ns/1ns

module machine_timer import soc_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     sel,
    input  tgt_req_t tgt_req,
    output tgt_rsp_t rsp,
    output logic     mtip
);
    logic [DATA_W-1:0] mtime;
    logic [DATA_W-1:0] mtimecmp;
    logic [DATA_W-1:0] rd_data;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= DATA_W'(MTIMECMP_RESET);
        end else begin
            mtime <= mtime + 1'b1; // free running, writes ignored
            if (sel && tgt_req.is_write && tgt_req.offset == MTIMECMP_ADDR) begin
                mtimecmp <= tgt_req.wdata;
            end
        end
    end

    always_comb begin
        if (tgt_req.offset == MTIME_ADDR)
            rd_data = mtime;
        else if (tgt_req.offset == MTIMECMP_ADDR)
            rd_data = mtimecmp;
        else
            rd_data = '0;
    end

    assign rsp  = '{ack: sel, rdata: rd_data};
    assign mtip = (mtime >= mtimecmp);

endmodule

// ==== mem_port.sv ====
`timescale 1ns/1ns

module mem_port import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     sel,
    input  tgt_req_t tgt_req,
    output tgt_rsp_t rsp
);
    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [WORD_W-1:0] ram [RAM_WORDS];
    logic              beat;     // second word of a 64-bit access
    logic [WORD_W-1:0] lo_q;     // low word held for ld
    logic              is_d;
    logic [1:0]        lane;
    logic [IDX_W-1:0]  word_idx;
    logic [WORD_W-1:0] rd_word;
    logic [WORD_W-1:0] shifted;
    logic [3:0]        be;
    logic [WORD_W-1:0] wr_word;
    logic [DATA_W-1:0] ld_data;
    logic [2:0]        align_mask;

    assign is_d     = (tgt_req.ls_type[1:0] == 2'b11);
    assign lane     = tgt_req.offset[1:0];
    assign word_idx = tgt_req.offset[2 +: IDX_W] + IDX_W'(beat);
    assign rd_word  = ram[word_idx];
    assign shifted  = rd_word >> (8 * lane); // addressed lane down to bit 0

    // load extension
    always_comb begin
        case (tgt_req.ls_type)
            LS_B:    ld_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
            LS_BU:   ld_data = DATA_W'(shifted[7:0]);
            LS_H:    ld_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
            LS_HU:   ld_data = DATA_W'(shifted[15:0]);
            LS_W:    ld_data = {{(DATA_W-32){shifted[31]}}, shifted[31:0]};
            LS_WU:   ld_data = DATA_W'(shifted[31:0]);
            LS_D:    ld_data = {rd_word, lo_q}; // high word on the second beat
            default: ld_data = '0;
        endcase
    end

    // byte lanes and replicated store data
    always_comb begin
        case (tgt_req.ls_type[1:0])
            2'b00: begin
                be      = 4'b0001 << lane;
                wr_word = {4{tgt_req.wdata[7:0]}};
            end
            2'b01: begin
                be      = 4'b0011 << lane;
                wr_word = {2{tgt_req.wdata[15:0]}};
            end
            2'b10: begin
                be      = 4'b1111;
                wr_word = tgt_req.wdata[31:0];
            end
            default: begin
                be      = 4'b1111;
                wr_word = beat ? tgt_req.wdata[63:32] : tgt_req.wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (sel && tgt_req.is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) ram[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
            end
        end
        if (sel && is_d && !beat) lo_q <= rd_word;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= 1'b0;
        end else if (sel && is_d) begin
            beat <= ~beat;
        end else begin
            beat <= 1'b0;
        end
    end

    assign rsp = '{ack: sel && (!is_d || beat), rdata: ld_data};

    // low address bits that must be zero for the access size
    always_comb begin
        case (tgt_req.ls_type[1:0])
            2'b00:   align_mask = 3'b000;
            2'b01:   align_mask = 3'b001;
            2'b10:   align_mask = 3'b011;
            default: align_mask = 3'b111;
        endcase
    end

    a_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sel |-> ((tgt_req.offset[2:0] & align_mask) == 3'b000))
        else $error("misaligned RAM access at offset %h", tgt_req.offset);

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int WORD_W = 32; // one RAM word

    // address map
    localparam logic [ADDR_W-1:0] RAM_BASE      = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 32'h0200_4000;
    localparam logic [ADDR_W-1:0] MTIME_ADDR    = 32'h0200_BFF8;
    localparam logic [ADDR_W-1:0] PLIC_BASE     = 32'h0C00_0000;
    localparam logic [ADDR_W-1:0] PLIC_SIZE     = 32'h0040_0000;

    // plic register offsets from PLIC_BASE
    localparam logic [ADDR_W-1:0] PLIC_PENDING_OFS       = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE_OFS        = 32'h0000_2000;
    localparam logic [ADDR_W-1:0] PLIC_CTX_ENABLE_STRIDE = 32'h0000_0080;
    localparam logic [ADDR_W-1:0] PLIC_THRESHOLD_OFS     = 32'h0020_0000;
    localparam logic [ADDR_W-1:0] PLIC_CLAIM_OFS         = 32'h0020_0004;
    localparam logic [ADDR_W-1:0] PLIC_CTX_STRIDE        = 32'h0000_1000;

    localparam logic [ADDR_W-1:0] MTIMECMP_RESET = 32'h8000_0000;

    localparam int PRIO_W = 3; // priority and threshold width

    // bit 2 set means zero extend, bits 1:0 give the size
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_t;

    // master side of the load/store port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        ls_type_t          ls_type;
        logic [DATA_W-1:0] wdata;
        logic              rd_en;
        logic              wr_en;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              read_done;
        logic              write_done;
    } bus_rsp_t;

    // shared request from the decoder to every target
    typedef struct packed {
        logic [ADDR_W-1:0] offset;
        ls_type_t          ls_type;
        logic [DATA_W-1:0] wdata;
        logic              is_write;
    } tgt_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] rdata;
    } tgt_rsp_t;

endpackage
